/* tb.f */
src/agg_pkg.sv
src/agg_stream_if.sv
src/beat_fifo.sv
src/header_capture.sv
src/lane_adder.sv
src/header_replay.sv
src/agg_top.sv
test/agg_assertions.sv
test/agg_tb.sv

/* run.sh */
#!/bin/sh
# build and run the aggregator testbench with Verilator
# exit status is non-zero when the run reports a failure

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module agg_tb -f tb.f -o agg_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/agg_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || { echo "run ended without a result"; exit 1; }
exit 0

/* test/agg_tb.sv */
// ========================================
// aggregator testbench
// random packet pairs on both ports with
// input gaps and random output ready
// ========================================
module agg_tb
  import agg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_pkts    = 20;
  localparam int max_pay     = 8;
  localparam int watchdog_ns = num_pkts * 13 * 8 * 4;

  typedef logic [data_width:0] beat_t;  // last in the top bit
  typedef beat_t beat_q_t [$];

  logic    axis_aclk;
  logic    axis_resetn;
  data_t   s_data  [num_ports];
  logic    s_last  [num_ports];
  logic    s_valid [num_ports];
  logic    s_ready [num_ports];
  data_t   m_data  [num_ports];
  logic    m_last  [num_ports];
  logic    m_valid [num_ports];
  logic    m_ready [num_ports];

  beat_q_t stim_q    [num_ports];  // sent beats per port
  beat_q_t exp_q     [num_ports];
  int      exp_total [num_ports];
  int      recv_cnt  [num_ports];
  int      err_data  [num_ports];
  int      err_other;

  agg_top u_agg_top (
    .axis_aclk      (axis_aclk),
    .axis_resetn    (axis_resetn),
    .s_axis_0_data  (s_data[0]),
    .s_axis_0_last  (s_last[0]),
    .s_axis_0_valid (s_valid[0]),
    .s_axis_0_ready (s_ready[0]),
    .s_axis_1_data  (s_data[1]),
    .s_axis_1_last  (s_last[1]),
    .s_axis_1_valid (s_valid[1]),
    .s_axis_1_ready (s_ready[1]),
    .m_axis_0_data  (m_data[0]),
    .m_axis_0_last  (m_last[0]),
    .m_axis_0_valid (m_valid[0]),
    .m_axis_0_ready (m_ready[0]),
    .m_axis_1_data  (m_data[1]),
    .m_axis_1_last  (m_last[1]),
    .m_axis_1_valid (m_valid[1]),
    .m_axis_1_ready (m_ready[1])
  );

  bind agg_top agg_assertions u_assertions (
    .axis_aclk      (axis_aclk),
    .axis_resetn    (axis_resetn),
    .m_axis_0_data  (m_axis_0_data),
    .m_axis_0_last  (m_axis_0_last),
    .m_axis_0_valid (m_axis_0_valid),
    .m_axis_0_ready (m_axis_0_ready),
    .m_axis_1_data  (m_axis_1_data),
    .m_axis_1_last  (m_axis_1_last),
    .m_axis_1_valid (m_axis_1_valid),
    .m_axis_1_ready (m_axis_1_ready)
  );

  // port p output: own header with broadcast MAC, then lane sums
  function automatic beat_q_t expected_packet(input beat_q_t pkt0, input beat_q_t pkt1,
                                              input int p);
    beat_q_t out_q;
    data_t   word;
    lane_t   a;
    lane_t   b;
    lane_t   s;
    int      n;
    n = pkt0.size();
    for (int i = 0; i < hdr_beats; i++) begin
      word = (p == 0) ? pkt0[i][data_width-1:0] : pkt1[i][data_width-1:0];
      if (i == 0) word[dest_mac_width-1:0] = bcast_mac;
      out_q.push_back({1'b0, word});
    end
    for (int i = hdr_beats; i < n; i++) begin
      for (int l = 0; l < num_lanes; l++) begin
        a = {<<8{pkt0[i][l*lane_width +: lane_width]}};  // to host order
        b = {<<8{pkt1[i][l*lane_width +: lane_width]}};
        s = a + b;  // wraps modulo 2^32
        word[l*lane_width +: lane_width] = {<<8{s}};
      end
      out_q.push_back({i == n - 1, word});
    end
    return out_q;
  endfunction

  task automatic send_stream(input int p);
    int idx;
    idx = 0;
    while (idx < stim_q[p].size()) begin
      @(posedge axis_aclk);
      if (s_valid[p] && s_ready[p]) idx++;  // taken at this edge
      if (!s_valid[p] || s_ready[p]) begin
        if (idx < stim_q[p].size() && $urandom_range(0, 3) != 0) begin
          s_data[p]  <= stim_q[p][idx][data_width-1:0];
          s_last[p]  <= stim_q[p][idx][data_width];
          s_valid[p] <= 1'b1;
        end else begin
          s_valid[p] <= 1'b0;  // gap
        end
      end
    end
  endtask

  task automatic check_stream(input int p);
    beat_t got;
    beat_t want;
    forever begin
      @(posedge axis_aclk);
      if (m_valid[p] && m_ready[p]) begin
        got = {m_last[p], m_data[p]};
        assert (exp_q[p].size() > 0) else begin
          $display("port %0d put out a beat after its last expected packet", p);
          err_other++;
        end
        if (exp_q[p].size() > 0) begin
          want = exp_q[p].pop_front();
          assert (got == want) else begin
            $display("FAIL %0t: port %0d beat %0d got last %0b data %h, expected last %0b data %h",
                     $time, p, recv_cnt[p], got[data_width], got[data_width-1:0],
                     want[data_width], want[data_width-1:0]);
            err_data[p]++;
          end
          recv_cnt[p]++;
        end
      end
    end
  endtask

  task automatic finish_run();
    int err_assert;
    err_assert = u_agg_top.u_assertions.fail_cnt;
    $display("errors: port 0 data %0d, port 1 data %0d, other %0d, assertions %0d",
             err_data[0], err_data[1], err_other, err_assert);
    if (err_data[0] + err_data[1] + err_other + err_assert == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    axis_aclk = 1'b0;
    forever #2 axis_aclk = ~axis_aclk;
  end

  initial begin
    forever begin
      @(posedge axis_aclk);
      for (int p = 0; p < num_ports; p++) begin
        m_ready[p] <= ($urandom_range(0, 3) != 0);  // random sink stalls
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: not all packets came out within %0d ns", watchdog_ns);
    err_other++;
    finish_run();
  end

  initial begin
    beat_q_t pkt [num_ports];
    beat_q_t res;
    int      n_pay;
    void'($urandom(32'heeb6));
    axis_resetn = 1'b0;
    err_other   = 0;
    for (int p = 0; p < num_ports; p++) begin
      s_data[p]   = '0;
      s_last[p]   = 1'b0;
      s_valid[p]  = 1'b0;
      m_ready[p]  = 1'b0;
      recv_cnt[p] = 0;
      err_data[p] = 0;
    end

    // packet pairs share one payload length
    for (int i = 0; i < num_pkts; i++) begin
      n_pay = $urandom_range(1, max_pay);
      for (int p = 0; p < num_ports; p++) begin
        pkt[p].delete();
        for (int b = 0; b < hdr_beats + n_pay; b++) begin
          pkt[p].push_back({b == hdr_beats + n_pay - 1, $urandom, $urandom});
          stim_q[p].push_back(pkt[p][b]);
        end
      end
      for (int p = 0; p < num_ports; p++) begin
        res = expected_packet(pkt[0], pkt[1], p);
        foreach (res[k]) exp_q[p].push_back(res[k]);
      end
    end
    for (int p = 0; p < num_ports; p++) exp_total[p] = exp_q[p].size();

    for (int c = 0; c < 16; c++) begin
      @(posedge axis_aclk);
      if (c > 0) begin
        assert (!m_valid[0] && !m_valid[1]) else begin
          $display("FAIL %0t: output valid high during reset", $time);
          err_other++;
        end
      end
    end
    axis_resetn <= 1'b1;

    // first cycle out of reset
    @(posedge axis_aclk);
    assert (!m_valid[0] && !m_valid[1]) else begin
      $display("FAIL %0t: output valid high right after reset", $time);
      err_other++;
    end
    assert (s_ready[0] && s_ready[1]) else begin
      $display("FAIL %0t: input ready low right after reset", $time);
      err_other++;
    end

    fork
      send_stream(0);
      send_stream(1);
      check_stream(0);
      check_stream(1);
    join_none

    wait (recv_cnt[0] == exp_total[0] && recv_cnt[1] == exp_total[1]);
    repeat (20) @(posedge axis_aclk);  // catch stray beats
    finish_run();
  end

endmodule

/* test/agg_assertions.sv */
// ========================================
// output stream protocol checks
// valid low after reset, stalled beats
// held until the sink takes them
// ========================================
module agg_assertions
  import agg_pkg::*;
(
  input logic  axis_aclk,
  input logic  axis_resetn,
  input data_t m_axis_0_data,
  input logic  m_axis_0_last,
  input logic  m_axis_0_valid,
  input logic  m_axis_0_ready,
  input data_t m_axis_1_data,
  input logic  m_axis_1_last,
  input logic  m_axis_1_valid,
  input logic  m_axis_1_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // assertion failures so far

  // nothing leaves the design right after a reset cycle
  a_rst_0: assert property (@(posedge axis_aclk) !axis_resetn |=> !m_axis_0_valid)
    else begin
      $error("port 0 valid high after a reset cycle");
      fail_cnt++;
    end
  a_rst_1: assert property (@(posedge axis_aclk) !axis_resetn |=> !m_axis_1_valid)
    else begin
      $error("port 1 valid high after a reset cycle");
      fail_cnt++;
    end

  a_hold_0: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    m_axis_0_valid && !m_axis_0_ready |=>
      m_axis_0_valid && $stable(m_axis_0_data) && $stable(m_axis_0_last))
    else begin
      $error("port 0 beat changed while stalled");
      fail_cnt++;
    end
  a_hold_1: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    m_axis_1_valid && !m_axis_1_ready |=>
      m_axis_1_valid && $stable(m_axis_1_data) && $stable(m_axis_1_last))
    else begin
      $error("port 1 beat changed while stalled");
      fail_cnt++;
    end

endmodule

/* src/agg_top.sv */
// ========================================
// two-port vector aggregator
// each port gets its own rewritten header
// followed by the summed payload
// ========================================
module agg_top
  import agg_pkg::*;
(
  input  logic  axis_aclk,
  input  logic  axis_resetn,

  input  data_t s_axis_0_data,
  input  logic  s_axis_0_last,
  input  logic  s_axis_0_valid,
  output logic  s_axis_0_ready,

  input  data_t s_axis_1_data,
  input  logic  s_axis_1_last,
  input  logic  s_axis_1_valid,
  output logic  s_axis_1_ready,

  output data_t m_axis_0_data,
  output logic  m_axis_0_last,
  output logic  m_axis_0_valid,
  input  logic  m_axis_0_ready,

  output data_t m_axis_1_data,
  output logic  m_axis_1_last,
  output logic  m_axis_1_valid,
  input  logic  m_axis_1_ready
);

  agg_stream_if in_s  [num_ports] ();  // top ports into ingress FIFO
  agg_stream_if cap_s [num_ports] ();  // ingress FIFO to splitter
  agg_stream_if hdr_w [num_ports] ();
  agg_stream_if hdr_r [num_ports] ();
  agg_stream_if pay_s [num_ports] ();  // splitter to adder
  agg_stream_if res_w [num_ports] ();
  agg_stream_if res_r [num_ports] ();
  agg_stream_if out_s [num_ports] ();

  assign in_s[0].data   = s_axis_0_data;
  assign in_s[0].last   = s_axis_0_last;
  assign in_s[0].valid  = s_axis_0_valid;
  assign s_axis_0_ready = in_s[0].ready;

  assign in_s[1].data   = s_axis_1_data;
  assign in_s[1].last   = s_axis_1_last;
  assign in_s[1].valid  = s_axis_1_valid;
  assign s_axis_1_ready = in_s[1].ready;

  assign m_axis_0_data  = out_s[0].data;
  assign m_axis_0_last  = out_s[0].last;
  assign m_axis_0_valid = out_s[0].valid;
  assign out_s[0].ready = m_axis_0_ready;

  assign m_axis_1_data  = out_s[1].data;
  assign m_axis_1_last  = out_s[1].last;
  assign m_axis_1_valid = out_s[1].valid;
  assign out_s[1].ready = m_axis_1_ready;

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    beat_fifo u_in_fifo (
      .axis_aclk, .axis_resetn, .wr(in_s[p]), .rd(cap_s[p])
    );
    header_capture u_capture (
      .axis_aclk, .axis_resetn, .in(cap_s[p]), .hdr(hdr_w[p]), .pay(pay_s[p])
    );
    beat_fifo u_hdr_fifo (
      .axis_aclk, .axis_resetn, .wr(hdr_w[p]), .rd(hdr_r[p])
    );
    beat_fifo u_res_fifo (
      .axis_aclk, .axis_resetn, .wr(res_w[p]), .rd(res_r[p])
    );
    header_replay u_replay (
      .axis_aclk, .axis_resetn, .hdr(hdr_r[p]), .res(res_r[p]), .out(out_s[p])
    );
  end

  // one adder shared by both ports
  lane_adder u_adder (
    .pay(pay_s),
    .res(res_w)
  );

endmodule

/* src/header_replay.sv */
// ========================================
// per-port output sequencer
// sends the stored header beats, then
// result beats up to the one with last
// ========================================
module header_replay
  import agg_pkg::*;
(
  input logic          axis_aclk,
  input logic          axis_resetn,
  agg_stream_if.sink   hdr,
  agg_stream_if.sink   res,
  agg_stream_if.source out
);

  typedef enum logic {
    ph_header,
    ph_result
  } phase_t;

  typedef logic [$clog2(hdr_beats)-1:0] cnt_t;

  phase_t phase;
  cnt_t   cnt;    // header beats sent
  logic   sent;

  always_comb begin
    if (phase == ph_header) begin
      out.data  = hdr.data;
      out.last  = 1'b0;           // packet continues with results
      out.valid = hdr.valid;
      hdr.ready = out.ready;
      res.ready = 1'b0;
    end else begin
      out.data  = res.data;
      out.last  = res.last;
      out.valid = res.valid;
      hdr.ready = 1'b0;
      res.ready = out.ready;
    end
  end

  assign sent = out.valid & out.ready;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      phase <= ph_header;
      cnt   <= '0;
    end else if (sent) begin
      case (phase)
        ph_header: begin
          if (cnt == cnt_t'(hdr_beats - 1)) begin
            cnt   <= '0;
            phase <= ph_result;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ph_result: begin
          if (res.last) phase <= ph_header;  // packet done
        end
        default: phase <= ph_header;
      endcase
    end
  end

endmodule

/* src/lane_adder.sv */
// ========================================
// payload lane adder
// sums both ports' lanes beat by beat
// and feeds every result FIFO
// ========================================
module lane_adder
  import agg_pkg::*;
(
  agg_stream_if.sink   pay [num_ports],
  agg_stream_if.source res [num_ports]
);

  logic [num_ports-1:0] pay_valid;
  logic [num_ports-1:0] res_ready;
  data_t                pay_data [num_ports];
  data_t                sum_data;
  logic                 fire;  // all inputs present, all outputs free

  assign fire = (&pay_valid) & (&res_ready);

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    assign pay_valid[p] = pay[p].valid;
    assign pay_data[p]  = pay[p].data;
    assign res_ready[p] = res[p].ready;

    assign pay[p].ready = fire;
    assign res[p].valid = fire;
    assign res[p].data  = sum_data;
    assign res[p].last  = pay[0].last;  // payloads have equal length
  end

  // add in host order, wraps modulo 2^32
  always_comb begin
    lane_t acc;
    sum_data = '0;
    for (int l = 0; l < num_lanes; l++) begin
      acc = '0;
      for (int p = 0; p < num_ports; p++) begin
        acc = acc + swap_bytes(pay_data[p][l*lane_width +: lane_width]);
      end
      sum_data[l*lane_width +: lane_width] = swap_bytes(acc);
    end
  end

endmodule

/* src/header_capture.sv */
// ========================================
// per-port header splitter
// diverts the header beats with the
// destination MAC set to broadcast and
// passes payload beats to the adder
// ========================================
module header_capture
  import agg_pkg::*;
(
  input logic          axis_aclk,
  input logic          axis_resetn,
  agg_stream_if.sink   in,
  agg_stream_if.source hdr,
  agg_stream_if.source pay
);

  typedef logic [$clog2(hdr_beats+1)-1:0] cnt_t;

  cnt_t  cnt;        // header beats seen in this packet
  logic  in_hdr;     // current beat belongs to the header
  logic  take;
  data_t hdr_word;

  assign in_hdr = (cnt != cnt_t'(hdr_beats));

  // MAC rewrite only on the first header beat
  always_comb begin
    hdr_word = in.data;
    if (cnt == '0) begin
      hdr_word[dest_mac_width-1:0] = bcast_mac;
    end
  end

  // header branch
  assign hdr.data  = hdr_word;
  assign hdr.last  = in.last;
  assign hdr.valid = in.valid & in_hdr;

  // payload branch, untouched
  assign pay.data  = in.data;
  assign pay.last  = in.last;
  assign pay.valid = in.valid & ~in_hdr;

  // stall follows whichever branch the beat goes to
  assign in.ready = in_hdr ? hdr.ready : pay.ready;
  assign take     = in.valid & in.ready;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      cnt <= '0;
    end else if (take) begin
      if (in.last) begin
        cnt <= '0;           // next packet starts with a header
      end else if (in_hdr) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

/* src/beat_fifo.sv */
// ========================================
// fall-through beat FIFO
// circular buffer of data and last,
// ready taken from free space
// ========================================
module beat_fifo
  import agg_pkg::*;
(
  input logic          axis_aclk,
  input logic          axis_resetn,
  agg_stream_if.sink   wr,
  agg_stream_if.source rd
);

  typedef logic [$clog2(fifo_depth)-1:0]   ptr_t;
  typedef logic [$clog2(fifo_depth+1)-1:0] count_t;

  data_t  mem_data [fifo_depth];
  logic   mem_last [fifo_depth];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;   // beats held
  logic   push;
  logic   pop;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr.ready = (count != count_t'(fifo_depth));  // low only when full
  assign rd.valid = (count != '0);
  assign rd.data  = mem_data[rd_ptr];  // head shows without a read
  assign rd.last  = mem_last[rd_ptr];

  assign push = wr.valid & wr.ready;
  assign pop  = rd.valid & rd.ready;

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      mem_data[wr_ptr] <= wr.data;
      mem_last[wr_ptr] <= wr.last;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

endmodule

/* src/agg_stream_if.sv */
// ========================================
// valid/ready beat stream
// one beat moves when valid and ready
// are both high at a rising edge
// ========================================
interface agg_stream_if
  import agg_pkg::*;
();

  data_t data;
  logic  last;   // final beat of a packet
  logic  valid;
  logic  ready;

  // producer side, holds data and last while stalled
  modport source (
    output data,
    output last,
    output valid,
    input  ready
  );

  // consumer side
  modport sink (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

/* src/agg_pkg.sv */
// ========================================
// aggregator shared definitions
// beat and lane widths, header length,
// broadcast MAC and lane byte swap
// ========================================
package agg_pkg;

  // ports taking part in every aggregation
  localparam int num_ports = 2;

  // stream beat and summed lane sizes
  localparam int data_width = 64;
  localparam int lane_width = 32;
  localparam int num_lanes  = data_width / lane_width;

  // 320 header bits ahead of the payload
  localparam int hdr_beats = 5;

  // destination MAC sits in bits 47:0 of header beat 0
  localparam int dest_mac_width = 48;
  localparam logic [dest_mac_width-1:0] bcast_mac = {dest_mac_width{1'b1}};

  localparam int fifo_depth = 16;  // beats, every FIFO

  typedef logic [data_width-1:0] data_t;
  typedef logic [lane_width-1:0] lane_t;

  // lanes arrive in network byte order
  function automatic lane_t swap_bytes(input lane_t v);
    lane_t r;
    for (int b = 0; b < lane_width / 8; b++) begin
      r[b*8 +: 8] = v[(lane_width/8 - 1 - b)*8 +: 8];
    end
    return r;
  endfunction

endpackage
